// ==== tb_patterns.mem ====
// kind: 0 idle, 1 write, 2 read, 3 set gpio_in to wdt, f end of patterns
// kind adr byt wdt exp_rdt exp_err exp_gpio({gpio_oe,gpio_out})
0 0000 0 00000000 00000000 0 00000000
1 0000 f 11223344 00000000 0 00000000
1 0004 f a5a5a5a5 00000000 0 00000000
1 0800 f deadbeef 00000000 0 00000000
1 0ffc f 0badf00d 00000000 0 00000000
2 0000 f 00000000 11223344 0 00000000
2 0004 f 00000000 a5a5a5a5 0 00000000
2 0800 f 00000000 deadbeef 0 00000000
2 0ffc f 00000000 0badf00d 0 00000000
// byte lane merge and partial reads
1 0004 1 000000c3 00000000 0 00000000
1 0004 4 00e70000 00000000 0 00000000
2 0004 f 00000000 a5e7a5c3 0 00000000
2 0004 3 00000000 0000a5c3 0 00000000
2 0004 c 00000000 a5e70000 0 00000000
// back to back write and read of one address
1 0010 f cafef00d 00000000 0 00000000
2 0010 f 00000000 cafef00d 0 00000000
1 0010 2 00005500 00000000 0 00000000
2 0010 f 00000000 cafe550d 0 00000000
// gpio out and dir, upper wdt bits ignored
1 1000 3 ffffbeef 00000000 0 0000beef
1 1004 1 000000f0 00000000 0 00f0beef
1 1004 2 00000a00 00000000 0 0af0beef
2 1000 f 00000000 0000beef 0 0af0beef
2 1004 f 00000000 00000af0 0 0af0beef
2 1000 1 00000000 000000ef 0 0af0beef
// gpio in through the synchronizer
3 0000 0 00005a3c 00000000 0 0af0beef
0 0000 0 00000000 00000000 0 0af0beef
0 0000 0 00000000 00000000 0 0af0beef
0 0000 0 00000000 00000000 0 0af0beef
2 1008 f 00000000 00005a3c 0 0af0beef
1 1008 3 0000ffff 00000000 0 0af0beef
2 1008 f 00000000 00005a3c 0 0af0beef
2 100c f 00000000 00000000 0 0af0beef
// unmapped windows, then confirm nothing changed
1 2000 f 12345678 00000000 1 0af0beef
2 2000 f 00000000 00000000 1 0af0beef
1 1100 3 00001111 00000000 1 0af0beef
2 1100 f 00000000 00000000 1 0af0beef
2 0000 f 00000000 11223344 0 0af0beef
2 1000 f 00000000 0000beef 0 0af0beef
0 0000 0 00000000 00000000 0 0af0beef
f 0000 0 00000000 00000000 0 00000000

// ==== build.f ====
tcb_pkg.sv
soc_pkg.sv
soc_memory.sv
soc_gpio.sv
soc_decoder.sv
soc_top.sv
tb_soc.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/Vtb_soc: build.f *.sv
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_soc -f build.f

run: obj_dir/Vtb_soc tb_patterns.mem
	./obj_dir/Vtb_soc | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/10ps --top-module soc_top \
		tcb_pkg.sv soc_pkg.sv soc_memory.sv soc_gpio.sv soc_decoder.sv soc_top.sv

clean:
	rm -rf obj_dir sim.log

// ==== tb_soc.sv ====
`timescale 1ns/10ps

module tb_soc;

  ////////////////////////////////////////
  // setup
  ////////////////////////////////////////

  // reset length in clock cycles
  localparam int unsigned RST_CYC = 16;
  // pattern table capacity and fields per line
  localparam int unsigned PAT_MAX = 128;
  localparam int unsigned PAT_COL = 7;

  // line kinds of the pattern file
  typedef enum logic [3:0] {
    K_IDLE  = 4'h0,
    K_WRITE = 4'h1,
    K_READ  = 4'h2,
    K_PIN   = 4'h3,
    K_END   = 4'hf
  } kind_e;

  logic                       tcb;
  logic                       arst_n;
  // bus request
  logic                       vld;
  logic                       wen;
  tcb_pkg::tcb_addr_t         adr;
  tcb_pkg::tcb_byte_t         byt;
  tcb_pkg::tcb_data_t         wdt;
  // bus response
  logic                       rdy;
  tcb_pkg::tcb_data_t         rdt;
  logic                       err;
  // pins
  logic [soc_pkg::GPIO_W-1:0] gpio_in;
  logic [soc_pkg::GPIO_W-1:0] gpio_out;
  logic [soc_pkg::GPIO_W-1:0] gpio_oe;

  // pattern table, PAT_COL words per line
  logic [31:0]                pat [0:PAT_MAX*PAT_COL-1];
  int unsigned                n_pat;
  logic                       started;
  // error counts per kind of result
  int unsigned                n_data_err;
  int unsigned                n_flag_err;
  int unsigned                n_gpio_err;
  int unsigned                n_other_err;

  soc_top i_soc_top (
    .tcb      (tcb),
    .arst_n   (arst_n),
    .vld      (vld),
    .wen      (wen),
    .adr      (adr),
    .byt      (byt),
    .wdt      (wdt),
    .rdy      (rdy),
    .rdt      (rdt),
    .err      (err),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  // 8 ns period
  always #4 tcb = ~tcb;

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input tcb_pkg::tcb_data_t exp,
                            input tcb_pkg::tcb_data_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected %h, actual %h", $time, name, exp, act);
      n_data_err++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected %b, actual %b", $time, name, exp, act);
      n_flag_err++;
    end
  endtask

  task automatic check_gpio(input string name, input logic [soc_pkg::GPIO_W-1:0] exp,
                            input logic [soc_pkg::GPIO_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: expected %h, actual %h", $time, name, exp, act);
      n_gpio_err++;
    end
  endtask

  ////////////////////////////////////////
  // pattern lines
  ////////////////////////////////////////

  // put one line on the bus or on the pins, call right after a rising edge
  task automatic apply_line(input int unsigned i);
    kind_e k;
    k = kind_e'(pat[i*PAT_COL][3:0]);
    vld <= (k == K_WRITE) || (k == K_READ);
    wen <= (k == K_WRITE);
    adr <= tcb_pkg::tcb_addr_t'(pat[i*PAT_COL+1]);
    byt <= tcb_pkg::tcb_byte_t'(pat[i*PAT_COL+2]);
    wdt <= pat[i*PAT_COL+3];
    // pin value rides in the wdt column
    if (k == K_PIN) begin
      gpio_in <= pat[i*PAT_COL+3][soc_pkg::GPIO_W-1:0];
    end
  endtask

  // response of a line, one cycle after its transfer edge
  task automatic check_line(input int unsigned i);
    kind_e       k;
    logic [31:0] exp_pins;
    k        = kind_e'(pat[i*PAT_COL][3:0]);
    exp_pins = pat[i*PAT_COL+6];
    // rdt only means something after a read
    if (k == K_READ) begin
      check_data("rdt", pat[i*PAT_COL+4], rdt);
    end
    check_err("err", pat[i*PAT_COL+5][0], err);
    check_err("rdy", 1'b1, rdy);
    // gpio column holds oe in the upper half, out in the lower
    check_gpio("gpio_out", exp_pins[soc_pkg::GPIO_W-1:0], gpio_out);
    check_gpio("gpio_oe", exp_pins[2*soc_pkg::GPIO_W-1:soc_pkg::GPIO_W], gpio_oe);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    tcb         = 1'b0;
    arst_n      = 1'b0;
    vld         = 1'b0;
    wen         = 1'b0;
    adr         = '0;
    byt         = '0;
    wdt         = '0;
    gpio_in     = '0;
    n_pat       = 0;
    started     = 1'b0;
    n_data_err  = 0;
    n_flag_err  = 0;
    n_gpio_err  = 0;
    n_other_err = 0;
    $readmemh("tb_patterns.mem", pat);
    // lines up to the end marker
    while (n_pat < PAT_MAX && pat[n_pat*PAT_COL] !== 32'hf) begin
      n_pat++;
    end
    if (n_pat == 0) begin
      $display("no pattern lines were read from tb_patterns.mem");
      n_other_err++;
    end
    started = 1'b1;
    repeat (RST_CYC) @(posedge tcb);
    arst_n <= 1'b1;
    // state right after reset, before any transfer
    @(negedge tcb);
    check_err("err", 1'b0, err);
    check_data("rdt", '0, rdt);
    check_gpio("gpio_out", '0, gpio_out);
    check_gpio("gpio_oe", '0, gpio_oe);
    // drive line i, then check line i-1 whose transfer was at this edge
    for (int unsigned i = 0; i < n_pat; i++) begin
      @(posedge tcb);
      apply_line(i);
      @(negedge tcb);
      if (i > 0) begin
        check_line(i - 1);
      end
    end
    // one idle cycle to collect the last response
    @(posedge tcb);
    vld <= 1'b0;
    wen <= 1'b0;
    @(negedge tcb);
    if (n_pat > 0) begin
      check_line(n_pat - 1);
    end
    $display("errors: data %0d, flag %0d, gpio %0d, other %0d",
             n_data_err, n_flag_err, n_gpio_err, n_other_err);
    if (n_data_err + n_flag_err + n_gpio_err + n_other_err == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog, four times the expected run length
  initial begin
    int unsigned limit;
    wait (started);
    limit = (RST_CYC + n_pat + 10) * 8 * 4;
    #(limit);
    $display("timeout: the run did not finish within %0d ns", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== soc_top.sv ====
`timescale 1ns/10ps

module soc_top (
  input  logic                       tcb,
  input  logic                       arst_n,
  // bus from the requester
  input  logic                       vld,
  input  logic                       wen,
  input  tcb_pkg::tcb_addr_t         adr,
  input  tcb_pkg::tcb_byte_t         byt,
  input  tcb_pkg::tcb_data_t         wdt,
  output logic                       rdy,
  output tcb_pkg::tcb_data_t         rdt,
  output logic                       err,
  // pins
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out,
  output logic [soc_pkg::GPIO_W-1:0] gpio_oe
);

  ////////////////////////////////////////
  // internal bus
  ////////////////////////////////////////

  // per subordinate valid, the rest of the request is shared
  logic               mem_vld;
  logic               gpio_vld;
  // per subordinate read data
  tcb_pkg::tcb_data_t mem_rdt;
  tcb_pkg::tcb_data_t gpio_rdt;

  // decoder owns rdy and err
  soc_decoder i_decoder (
    .tcb      (tcb),
    .arst_n   (arst_n),
    .vld      (vld),
    .adr      (adr),
    .rdy      (rdy),
    .err      (err),
    .rdt      (rdt),
    .mem_vld  (mem_vld),
    .gpio_vld (gpio_vld),
    .mem_rdt  (mem_rdt),
    .gpio_rdt (gpio_rdt)
  );

  // memory at 0x0000
  soc_memory i_memory (
    .tcb     (tcb),
    .mem_vld (mem_vld),
    .wen     (wen),
    .adr     (adr),
    .byt     (byt),
    .wdt     (wdt),
    .mem_rdt (mem_rdt)
  );

  // GPIO at 0x1000
  soc_gpio i_gpio (
    .tcb      (tcb),
    .arst_n   (arst_n),
    .gpio_vld (gpio_vld),
    .wen      (wen),
    .adr      (adr),
    .byt      (byt),
    .wdt      (wdt),
    .gpio_in  (gpio_in),
    .gpio_rdt (gpio_rdt),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

endmodule

// ==== soc_decoder.sv ====
`timescale 1ns/10ps

module soc_decoder (
  input  logic               tcb,
  input  logic               arst_n,
  // requester side
  input  logic               vld,
  input  tcb_pkg::tcb_addr_t adr,
  output logic               rdy,
  output logic               err,
  output tcb_pkg::tcb_data_t rdt,
  // subordinate side
  output logic               mem_vld,
  output logic               gpio_vld,
  input  tcb_pkg::tcb_data_t mem_rdt,
  input  tcb_pkg::tcb_data_t gpio_rdt
);

  // transfer strobe
  logic             trn;
  // target of the current request
  soc_pkg::target_e tgt;
  // target and error of the previous transfer
  soc_pkg::target_e tgt_q;
  logic             err_q;

  // window match by masking, base aligned to a power of two size
  function automatic logic in_window(
    input tcb_pkg::tcb_addr_t a,
    input tcb_pkg::tcb_addr_t base,
    input tcb_pkg::tcb_addr_t size
  );
    tcb_pkg::tcb_addr_t mask;
    mask = ~(size - tcb_pkg::tcb_addr_t'(1));
    return (a & mask) == base;
  endfunction

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  // every target is always ready, no back-pressure
  assign rdy = 1'b1;
  assign trn = vld & rdy;

  always_comb begin
    if (in_window(adr, soc_pkg::MEM_BASE, soc_pkg::MEM_SIZE)) begin
      tgt = soc_pkg::TGT_MEM;
    end else if (in_window(adr, soc_pkg::GPIO_BASE, soc_pkg::GPIO_SIZE)) begin
      tgt = soc_pkg::TGT_GPIO;
    end else begin
      // unmapped, the error responder takes it
      tgt = soc_pkg::TGT_NONE;
    end
  end

  // only the selected subordinate sees vld
  assign mem_vld  = vld && (tgt == soc_pkg::TGT_MEM);
  assign gpio_vld = vld && (tgt == soc_pkg::TGT_GPIO);

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // idle cycles leave no target and no error behind
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      tgt_q <= soc_pkg::TGT_NONE;
      err_q <= 1'b0;
    end else begin
      tgt_q <= trn ? tgt : soc_pkg::TGT_NONE;
      err_q <= trn && (tgt == soc_pkg::TGT_NONE);
    end
  end

  // steer the data of the responding subordinate
  always_comb begin
    case (tgt_q)
      soc_pkg::TGT_MEM:  rdt = mem_rdt;
      soc_pkg::TGT_GPIO: rdt = gpio_rdt;
      // error responder returns zero
      default:           rdt = '0;
    endcase
  end

  // error for reads and writes alike
  assign err = err_q;

endmodule

// ==== soc_gpio.sv ====
`timescale 1ns/10ps

module soc_gpio (
  input  logic                        tcb,
  input  logic                        arst_n,
  // request, gpio_vld is already qualified by the decoder
  input  logic                        gpio_vld,
  input  logic                        wen,
  input  tcb_pkg::tcb_addr_t          adr,
  input  tcb_pkg::tcb_byte_t          byt,
  input  tcb_pkg::tcb_data_t          wdt,
  // pins
  input  logic [soc_pkg::GPIO_W-1:0]  gpio_in,
  // read data, valid one cycle after a read transfer
  output tcb_pkg::tcb_data_t          gpio_rdt,
  output logic [soc_pkg::GPIO_W-1:0]  gpio_out,
  output logic [soc_pkg::GPIO_W-1:0]  gpio_oe
);

  // register select from the offset inside the window
  soc_pkg::gpio_reg_e                 reg_sel;
  // direction register, 1 drives the pin
  logic [soc_pkg::GPIO_W-1:0]         gpio_dir;
  // input synchronizer stages
  logic [soc_pkg::GPIO_W-1:0]         gpio_in_meta;
  logic [soc_pkg::GPIO_W-1:0]         gpio_in_sync;
  // selected register and masked read word
  logic [soc_pkg::GPIO_W-1:0]         reg_rd;
  tcb_pkg::tcb_data_t                 rd_word;

  // byte-enabled merge of a write into a register
  function automatic logic [soc_pkg::GPIO_W-1:0] merge(
    input logic [soc_pkg::GPIO_W-1:0] old,
    input tcb_pkg::tcb_data_t         data,
    input tcb_pkg::tcb_byte_t         lanes
  );
    logic [soc_pkg::GPIO_W-1:0] res;
    res = old;
    for (int unsigned b = 0; b < soc_pkg::GPIO_BYT; b++) begin
      if (lanes[b]) begin
        res[8*b+:8] = data[8*b+:8];
      end
    end
    return res;
  endfunction

  // unused offsets map to no enum member and fall into the defaults
  assign reg_sel = soc_pkg::gpio_reg_e'(adr[soc_pkg::GPIO_OFS-1:0]);

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      gpio_out     <= '0;
      gpio_dir     <= '0;
      gpio_in_meta <= '0;
      gpio_in_sync <= '0;
    end else begin
      // two flop synchronizer, pin value visible after two edges
      gpio_in_meta <= gpio_in;
      gpio_in_sync <= gpio_in_meta;
      if (gpio_vld && wen) begin
        case (reg_sel)
          soc_pkg::GPIO_OUT: gpio_out <= merge(gpio_out, wdt, byt);
          soc_pkg::GPIO_DIR: gpio_dir <= merge(gpio_dir, wdt, byt);
          // GPIO_IN is read only, unused offsets are ignored
          default: ;
        endcase
      end
    end
  end

  assign gpio_oe = gpio_dir;

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  always_comb begin
    case (reg_sel)
      soc_pkg::GPIO_OUT: reg_rd = gpio_out;
      soc_pkg::GPIO_DIR: reg_rd = gpio_dir;
      soc_pkg::GPIO_IN:  reg_rd = gpio_in_sync;
      default:           reg_rd = '0;
    endcase
    // upper bits zero, then drop disabled lanes
    rd_word = tcb_pkg::tcb_data_t'(reg_rd);
    for (int unsigned b = 0; b < tcb_pkg::BUS_BYT; b++) begin
      if (!byt[b]) begin
        rd_word[8*b+:8] = 8'h00;
      end
    end
  end

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      gpio_rdt <= '0;
    end else if (gpio_vld && !wen) begin
      gpio_rdt <= rd_word;
    end
  end

endmodule

// ==== soc_memory.sv ====
`timescale 1ns/10ps

module soc_memory (
  input  logic               tcb,
  // request, mem_vld is already qualified by the decoder
  input  logic               mem_vld,
  input  logic               wen,
  input  tcb_pkg::tcb_addr_t adr,
  input  tcb_pkg::tcb_byte_t byt,
  input  tcb_pkg::tcb_data_t wdt,
  // read data, valid one cycle after a read transfer
  output tcb_pkg::tcb_data_t mem_rdt
);

  ////////////////////////////////////////
  // array
  ////////////////////////////////////////

  // one word per entry, contents undefined until written
  tcb_pkg::tcb_data_t mem [0:2**soc_pkg::MEM_ADR-1];

  // word index, byte offset bits dropped
  logic [soc_pkg::MEM_ADR-1:0] idx;

  // only the low window bits matter, the decoder already checked the rest
  assign idx = adr[soc_pkg::MEM_ADR+tcb_pkg::BUS_MAX-1:tcb_pkg::BUS_MAX];

  ////////////////////////////////////////
  // write and read access
  ////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (mem_vld) begin
      if (wen) begin
        // write, only enabled lanes are touched
        for (int unsigned b = 0; b < tcb_pkg::BUS_BYT; b++) begin
          if (byt[b]) begin
            mem[idx][8*b+:8] <= wdt[8*b+:8];
          end
        end
      end else begin
        // read, disabled lanes come back as zero
        for (int unsigned b = 0; b < tcb_pkg::BUS_BYT; b++) begin
          if (byt[b]) begin
            mem_rdt[8*b+:8] <= mem[idx][8*b+:8];
          end else begin
            mem_rdt[8*b+:8] <= 8'h00;
          end
        end
      end
    end
  end

  // mem_rdt holds its value across writes and idle cycles

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

  ////////////////////////////////////////
  // memory map
  ////////////////////////////////////////

  // windows must be power of two sized and aligned to their size
  localparam tcb_pkg::tcb_addr_t MEM_BASE  = 16'h0000;
  localparam tcb_pkg::tcb_addr_t MEM_SIZE  = 16'h1000;
  localparam tcb_pkg::tcb_addr_t GPIO_BASE = 16'h1000;
  localparam tcb_pkg::tcb_addr_t GPIO_SIZE = 16'h0100;

  // word index width inside the memory, 4kB of 32-bit words gives 10
  localparam int unsigned MEM_ADR = $clog2(MEM_SIZE) - tcb_pkg::BUS_MAX;

  ////////////////////////////////////////
  // GPIO block
  ////////////////////////////////////////

  // pin count
  localparam int unsigned GPIO_W   = 16;
  // byte lanes occupied by a GPIO register
  localparam int unsigned GPIO_BYT = GPIO_W / 8;
  // offset bits inside the GPIO window
  localparam int unsigned GPIO_OFS = $clog2(GPIO_SIZE);

  // register word offsets, anything else is unused and reads zero
  typedef enum logic [GPIO_OFS-1:0] {
    GPIO_OUT = 8'h00,
    GPIO_DIR = 8'h04,
    GPIO_IN  = 8'h08
  } gpio_reg_e;

  ////////////////////////////////////////
  // decoder
  ////////////////////////////////////////

  // TGT_NONE goes to the error responder
  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_GPIO,
    TGT_NONE
  } target_e;

endpackage

// ==== tcb_pkg.sv ====
package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // byte address width, covers the whole 64kB space
  localparam int unsigned BUS_ADR = 16;
  // data word width
  localparam int unsigned BUS_DAT = 32;
  // byte lanes per word
  localparam int unsigned BUS_BYT = BUS_DAT / 8;
  // address bits below word granularity
  localparam int unsigned BUS_MAX = $clog2(BUS_BYT);

  ////////////////////////////////////////
  // request and response fields
  ////////////////////////////////////////

  // byte address of a transfer
  typedef logic [BUS_ADR-1:0] tcb_addr_t;

  // one data word, lane b is bits [8*b+:8]
  typedef logic [BUS_DAT-1:0] tcb_data_t;

  // byte enable mask, one bit per lane
  typedef logic [BUS_BYT-1:0] tcb_byte_t;

endpackage
